// ==== Makefile ====
# Verilator build and run for the I2C slave testbench

VERILATOR ?= verilator
TOP       ?= tb_i2c_slave
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(wildcard hdl/*.sv) $(wildcard tests/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
hdl/i2c_slave_pkg.sv
hdl/i2c_glitch_filter.sv
hdl/i2c_filter_limits.sv
hdl/i2c_bus_conditions.sv
hdl/i2c_bit_framer.sv
hdl/i2c_transfer_ctrl.sv
hdl/i2c_register_bank.sv
hdl/i2c_slave_top.sv
tests/i2c_slave_properties.sv
tests/tb_i2c_slave.sv

// ==== hdl/i2c_bit_framer.sv ====
// Frame bit counter, receive shift register and master ACK capture
`timescale 1ns/1ps
`default_nettype none

module i2c_bit_framer (
	input  wire logic           clk,
	input  wire logic           rst,
	input  wire logic           i_scl_rise,
	input  wire logic           i_scl_fall,
	input  wire logic           i_sda_level,
	input  wire logic           i_start,
	output i2c_slave_pkg::byte_t o_rx_byte,
	output logic                o_lsb_bit,
	output logic                o_ack_bit,
	output logic                o_master_ack
);

	i2c_slave_pkg::bit_count_t bit_cnt_q;

	// Positions 7 and 8 of the frame, ignored during start
	assign o_lsb_bit = (bit_cnt_q == 4'd7) && !i_start;
	assign o_ack_bit = (bit_cnt_q == 4'd8) && !i_start;

	// Counts 0..8 on SCL falls
	always_ff @(posedge clk) begin
		if (rst)
			bit_cnt_q <= '0;
		else if (i_scl_fall && (o_ack_bit || i_start))
			bit_cnt_q <= '0;
		else if (i_scl_fall)
			bit_cnt_q <= bit_cnt_q + 4'd1;
	end

	// SDA is stable while SCL is high
	always_ff @(posedge clk) begin
		if (i_scl_rise && !o_ack_bit)
			o_rx_byte <= {o_rx_byte[6:0], i_sda_level};
	end

	// Low SDA on the ninth bit means master ACK
	always_ff @(posedge clk) begin
		if (rst)
			o_master_ack <= 1'b0;
		else if (i_scl_rise && o_ack_bit)
			o_master_ack <= ~i_sda_level;
	end

endmodule

`default_nettype wire

// ==== hdl/i2c_bus_conditions.sv ====
// Start and stop condition flags, each cleared after the following SCL rise
`timescale 1ns/1ps
`default_nettype none

module i2c_bus_conditions (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic i_sda_level,
	input  wire logic i_sda_rise,
	input  wire logic i_sda_fall,
	input  wire logic i_scl_level,
	input  wire logic i_scl_rise,
	output logic      o_start,
	output logic      o_stop
);

	logic start_clr_q;
	logic stop_clr_q;

	// SDA falling while SCL high, held until resetter fires
	always_ff @(posedge clk) begin
		if (rst || start_clr_q)
			o_start <= 1'b0;
		else if (i_sda_fall)
			o_start <= i_scl_level;
	end

	// SDA rising while SCL high
	always_ff @(posedge clk) begin
		if (rst || stop_clr_q)
			o_stop <= 1'b0;
		else if (i_sda_rise && i_sda_level)
			o_stop <= i_scl_level;
	end

	// Resetters follow the flags on each SCL rise
	always_ff @(posedge clk) begin
		if (rst) begin
			start_clr_q <= 1'b0;
			stop_clr_q  <= 1'b0;
		end else if (i_scl_rise) begin
			start_clr_q <= o_start;
			stop_clr_q  <= o_stop;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/i2c_filter_limits.sv ====
// Clamping of raw filter configuration bytes into legal width and thresholds
`timescale 1ns/1ps
`default_nettype none

module i2c_filter_limits (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire i2c_slave_pkg::byte_t i_width_raw,
	input  wire i2c_slave_pkg::byte_t i_one_raw,
	input  wire i2c_slave_pkg::byte_t i_zero_raw,
	output i2c_slave_pkg::filter_count_t o_width,
	output i2c_slave_pkg::filter_count_t o_one_threshold,
	output i2c_slave_pkg::filter_count_t o_zero_threshold
);

	i2c_slave_pkg::filter_count_t width_next;
	i2c_slave_pkg::filter_count_t half_width;
	i2c_slave_pkg::filter_count_t one_next;
	i2c_slave_pkg::filter_count_t zero_next;

	always_comb begin
		// Width into MIN..MAX
		if (int'(i_width_raw) > i2c_slave_pkg::FILTER_MAX_WIDTH)
			width_next = i2c_slave_pkg::filter_count_t'(i2c_slave_pkg::FILTER_MAX_WIDTH);
		else if (int'(i_width_raw) < i2c_slave_pkg::FILTER_MIN_WIDTH)
			width_next = i2c_slave_pkg::filter_count_t'(i2c_slave_pkg::FILTER_MIN_WIDTH);
		else
			width_next = i_width_raw[4:0];
		half_width = width_next >> 1;

		// One threshold between half width and width, else full width
		if (i_one_raw > {3'b000, width_next} || i_one_raw < {3'b000, half_width})
			one_next = width_next;
		else
			one_next = i_one_raw[4:0];

		// Zero threshold above half width is meaningless
		if (i_zero_raw > {3'b000, half_width})
			zero_next = '0;
		else
			zero_next = i_zero_raw[4:0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			o_width          <= i2c_slave_pkg::filter_count_t'(i2c_slave_pkg::FILTER_DEFAULT_WIDTH);
			o_one_threshold  <= i2c_slave_pkg::filter_count_t'(i2c_slave_pkg::FILTER_DEFAULT_ONE);
			o_zero_threshold <= i2c_slave_pkg::filter_count_t'(i2c_slave_pkg::FILTER_DEFAULT_ZERO);
		end else begin
			o_width          <= width_next;
			o_one_threshold  <= one_next;
			o_zero_threshold <= zero_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/i2c_glitch_filter.sv ====
// Line synchronizer, majority vote glitch filter with hysteresis and edge pulses
`timescale 1ns/1ps
`default_nettype none

module i2c_glitch_filter (
	input  wire logic                         clk,
	input  wire logic                         rst,
	input  wire logic                         i_line,
	input  wire i2c_slave_pkg::filter_count_t i_width,
	input  wire i2c_slave_pkg::filter_count_t i_one_threshold,
	input  wire i2c_slave_pkg::filter_count_t i_zero_threshold,
	output logic                              o_level,
	output logic                              o_rise,
	output logic                              o_fall
);

	localparam int MAX_W = i2c_slave_pkg::FILTER_MAX_WIDTH;

	// Three flop synchronizer, idle bus is high
	logic [2:0] sync_q;
	// Sample history, newest sample in bit 0
	logic [MAX_W-1:0] hist_q;
	i2c_slave_pkg::filter_count_t sum;
	logic level_q;
	logic level_prev_q;

	// ----------------------------------------------------------
	// Synchronizer and history
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q <= '1;
			hist_q <= '1;
		end else begin
			sync_q <= {sync_q[1:0], i_line};
			hist_q <= {hist_q[MAX_W-2:0], sync_q[2]};
		end
	end

	// Count ones among the newest i_width samples
	always_comb begin
		sum = '0;
		for (int i = 0; i < MAX_W; i++) begin
			if (i < int'(i_width))
				sum = sum + i2c_slave_pkg::filter_count_t'(hist_q[i]);
		end
	end

	// ----------------------------------------------------------
	// Hysteresis decision
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			level_q      <= 1'b1;
			level_prev_q <= 1'b1;
		end else begin
			// Between thresholds the level holds
			if (sum >= i_one_threshold)
				level_q <= 1'b1;
			else if (sum <= i_zero_threshold)
				level_q <= 1'b0;
			level_prev_q <= level_q;
		end
	end

	assign o_level = level_q;
	// Single cycle pulses on each filtered change
	assign o_rise  = level_q & ~level_prev_q;
	assign o_fall  = ~level_q & level_prev_q;

endmodule

`default_nettype wire

// ==== hdl/i2c_register_bank.sv ====
// Register map storage, write decode, read mux and core result capture
`timescale 1ns/1ps
`default_nettype none

module i2c_register_bank (
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic                      i_write,
	input  wire logic                      i_load,
	input  wire i2c_slave_pkg::reg_index_t i_index,
	input  wire i2c_slave_pkg::byte_t      i_rx_byte,
	input  wire i2c_slave_pkg::word_t      i_data_out,
	input  wire logic                      i_end_op,
	output i2c_slave_pkg::byte_t           o_read_byte,
	output i2c_slave_pkg::word_t           o_data_in,
	output i2c_slave_pkg::word_t           o_add,
	output i2c_slave_pkg::word_t           o_control,
	output i2c_slave_pkg::byte_t           o_width_raw,
	output i2c_slave_pkg::byte_t           o_one_raw,
	output i2c_slave_pkg::byte_t           o_zero_raw
);

	// Writable bytes sit below the result word
	localparam int NUM_WR = int'(i2c_slave_pkg::REG_DATA_OUT_BASE);

	i2c_slave_pkg::byte_t wr_regs [NUM_WR];
	i2c_slave_pkg::word_t data_out_q;
	logic end_op_q;

	// ----------------------------------------------------------
	// Write decode and result capture
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_WR; i++)
				wr_regs[i] <= '0;
			data_out_q  <= '0;
			end_op_q    <= 1'b0;
			o_width_raw <= i2c_slave_pkg::byte_t'(i2c_slave_pkg::FILTER_DEFAULT_WIDTH);
			o_one_raw   <= i2c_slave_pkg::byte_t'(i2c_slave_pkg::FILTER_DEFAULT_ONE);
			o_zero_raw  <= i2c_slave_pkg::byte_t'(i2c_slave_pkg::FILTER_DEFAULT_ZERO);
		end else if (i_write) begin
			// Unmapped and read only indexes drop the byte
			if (i_index < i2c_slave_pkg::REG_DATA_OUT_BASE)
				wr_regs[i_index[4:0]] <= i_rx_byte;
			else if (i_index == i2c_slave_pkg::REG_FILTER_WIDTH)
				o_width_raw <= i_rx_byte;
			else if (i_index == i2c_slave_pkg::REG_FILTER_ONE)
				o_one_raw <= i_rx_byte;
			else if (i_index == i2c_slave_pkg::REG_FILTER_ZERO)
				o_zero_raw <= i_rx_byte;
		end else begin
			data_out_q <= i_data_out;
			end_op_q   <= i_end_op;
		end
	end

	// Base index byte is the MSB of each word
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			o_data_in[8*(7-i) +: 8] = wr_regs[int'(i2c_slave_pkg::REG_DATA_IN_BASE) + i];
			o_add[8*(7-i) +: 8]     = wr_regs[int'(i2c_slave_pkg::REG_ADD_BASE) + i];
			o_control[8*(7-i) +: 8] = wr_regs[int'(i2c_slave_pkg::REG_CONTROL_BASE) + i];
		end
	end

	// ----------------------------------------------------------
	// Read mux, valid during the load pulse
	// ----------------------------------------------------------
	always_comb begin
		o_read_byte = '0;
		if (i_load) begin
			if (i_index < i2c_slave_pkg::REG_DATA_OUT_BASE)
				o_read_byte = wr_regs[i_index[4:0]];
			else if (i_index < i2c_slave_pkg::REG_DATA_OUT_BASE + 8'd8)
				// Result word is 8 aligned, low index bits pick the byte
				o_read_byte = data_out_q[8*(7-int'(i_index[2:0])) +: 8];
			else if (i_index == i2c_slave_pkg::REG_END_OP)
				o_read_byte = {7'b0, end_op_q};
			else if (i_index == i2c_slave_pkg::REG_FILTER_ZERO)
				o_read_byte = o_zero_raw;
			else if (i_index == i2c_slave_pkg::REG_FILTER_ONE)
				o_read_byte = o_one_raw;
			else if (i_index == i2c_slave_pkg::REG_FILTER_WIDTH)
				o_read_byte = o_width_raw;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/i2c_slave_pkg.sv ====
// Shared widths, controller state enum, register indexes and filter defaults
`default_nettype none

package i2c_slave_pkg;

	// ----------------------------------------------------------
	// Data widths
	// ----------------------------------------------------------
	typedef logic [7:0]  byte_t;
	typedef logic [63:0] word_t;
	typedef logic [7:0]  reg_index_t;
	typedef logic [6:0]  dev_addr_t;
	// Nine bit frame position, 8 data bits plus ACK
	typedef logic [3:0]  bit_count_t;
	// Filter sum, width and thresholds (up to 20)
	typedef logic [4:0]  filter_count_t;

	// Slave controller states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_DEV_ADDR,
		ST_READ,
		ST_IDX_PTR,
		ST_WRITE
	} slave_state_e;

	// ----------------------------------------------------------
	// Glitch filter limits and defaults
	// ----------------------------------------------------------
	localparam int FILTER_MAX_WIDTH     = 20;
	localparam int FILTER_MIN_WIDTH     = 3;
	localparam int FILTER_DEFAULT_WIDTH = 6;
	localparam int FILTER_DEFAULT_ONE   = 5;
	localparam int FILTER_DEFAULT_ZERO  = 1;

	// ----------------------------------------------------------
	// Register map
	// ----------------------------------------------------------
	localparam byte_t REG_DATA_IN_BASE  = 8'h00;
	localparam byte_t REG_ADD_BASE      = 8'h08;
	localparam byte_t REG_CONTROL_BASE  = 8'h10;
	localparam byte_t REG_DATA_OUT_BASE = 8'h18;
	// End of operation flag in bit 0
	localparam byte_t REG_END_OP        = 8'h27;
	localparam byte_t REG_FILTER_ZERO   = 8'hFD;
	localparam byte_t REG_FILTER_ONE    = 8'hFE;
	localparam byte_t REG_FILTER_WIDTH  = 8'hFF;

endpackage

`default_nettype wire

// ==== hdl/i2c_slave_top.sv ====
// I2C slave register interface top level, filters, framing, control and register map
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_top #(
	parameter i2c_slave_pkg::dev_addr_t DEVICE_ADDRESS = 7'h1A
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 i_scl,
	input  wire logic                 i_sda,
	input  wire i2c_slave_pkg::word_t i_data_out,
	input  wire logic                 i_end_op,
	output logic                      o_sda_release,
	output i2c_slave_pkg::word_t      o_data_in,
	output i2c_slave_pkg::word_t      o_add,
	output i2c_slave_pkg::word_t      o_control
);

	// Filtered lines
	logic scl_level, scl_rise, scl_fall;
	logic sda_level, sda_rise, sda_fall;
	// Filter configuration
	i2c_slave_pkg::filter_count_t width, one_thr, zero_thr;
	i2c_slave_pkg::byte_t width_raw, one_raw, zero_raw;
	// Framing and control
	logic start, stop;
	logic lsb_bit, ack_bit, master_ack;
	logic write, load;
	i2c_slave_pkg::byte_t rx_byte, read_byte;
	i2c_slave_pkg::reg_index_t index;

	// ----------------------------------------------------------
	// Line conditioning
	// ----------------------------------------------------------
	i2c_glitch_filter u_scl_filter (
		.clk(clk), .rst(rst), .i_line(i_scl),
		.i_width(width), .i_one_threshold(one_thr), .i_zero_threshold(zero_thr),
		.o_level(scl_level), .o_rise(scl_rise), .o_fall(scl_fall)
	);

	i2c_glitch_filter u_sda_filter (
		.clk(clk), .rst(rst), .i_line(i_sda),
		.i_width(width), .i_one_threshold(one_thr), .i_zero_threshold(zero_thr),
		.o_level(sda_level), .o_rise(sda_rise), .o_fall(sda_fall)
	);

	i2c_filter_limits u_filter_limits (
		.clk(clk), .rst(rst),
		.i_width_raw(width_raw), .i_one_raw(one_raw), .i_zero_raw(zero_raw),
		.o_width(width), .o_one_threshold(one_thr), .o_zero_threshold(zero_thr)
	);

	// ----------------------------------------------------------
	// Protocol
	// ----------------------------------------------------------
	i2c_bus_conditions u_bus_conditions (
		.clk(clk), .rst(rst),
		.i_sda_level(sda_level), .i_sda_rise(sda_rise), .i_sda_fall(sda_fall),
		.i_scl_level(scl_level), .i_scl_rise(scl_rise),
		.o_start(start), .o_stop(stop)
	);

	i2c_bit_framer u_bit_framer (
		.clk(clk), .rst(rst),
		.i_scl_rise(scl_rise), .i_scl_fall(scl_fall),
		.i_sda_level(sda_level), .i_start(start),
		.o_rx_byte(rx_byte), .o_lsb_bit(lsb_bit),
		.o_ack_bit(ack_bit), .o_master_ack(master_ack)
	);

	i2c_transfer_ctrl #(
		.DEVICE_ADDRESS(DEVICE_ADDRESS)
	) u_transfer_ctrl (
		.clk(clk), .rst(rst),
		.i_scl_fall(scl_fall), .i_start(start), .i_stop(stop),
		.i_lsb_bit(lsb_bit), .i_ack_bit(ack_bit), .i_master_ack(master_ack),
		.i_rx_byte(rx_byte), .i_read_byte(read_byte),
		.o_write(write), .o_load(load), .o_index(index),
		.o_sda_release(o_sda_release)
	);

	// Register map and core side words
	i2c_register_bank u_register_bank (
		.clk(clk), .rst(rst),
		.i_write(write), .i_load(load), .i_index(index), .i_rx_byte(rx_byte),
		.i_data_out(i_data_out), .i_end_op(i_end_op),
		.o_read_byte(read_byte),
		.o_data_in(o_data_in), .o_add(o_add), .o_control(o_control),
		.o_width_raw(width_raw), .o_one_raw(one_raw), .o_zero_raw(zero_raw)
	);

endmodule

`default_nettype wire

// ==== hdl/i2c_transfer_ctrl.sv ====
// Slave FSM, index pointer, transmit shift register and SDA release driver
`timescale 1ns/1ps
`default_nettype none

module i2c_transfer_ctrl #(
	parameter i2c_slave_pkg::dev_addr_t DEVICE_ADDRESS = 7'h1A
) (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 i_scl_fall,
	input  wire logic                 i_start,
	input  wire logic                 i_stop,
	input  wire logic                 i_lsb_bit,
	input  wire logic                 i_ack_bit,
	input  wire logic                 i_master_ack,
	input  wire i2c_slave_pkg::byte_t i_rx_byte,
	input  wire i2c_slave_pkg::byte_t i_read_byte,
	output logic                      o_write,
	output logic                      o_load,
	output i2c_slave_pkg::reg_index_t o_index,
	output logic                      o_sda_release
);

	i2c_slave_pkg::slave_state_e state_q;
	i2c_slave_pkg::byte_t tx_q;
	logic addr_match;
	logic rw_bit;
	logic slave_ack;
	logic send_next;

	// Address byte as received, R/W in bit 0
	assign addr_match = (i_rx_byte[7:1] == DEVICE_ADDRESS);
	assign rw_bit     = i_rx_byte[0];

	// Slave drives ACK for own address, index and write data
	assign slave_ack = ((state_q == i2c_slave_pkg::ST_DEV_ADDR) && addr_match) ||
	                   (state_q == i2c_slave_pkg::ST_IDX_PTR) ||
	                   (state_q == i2c_slave_pkg::ST_WRITE);
	// A read byte follows this ACK
	assign send_next = ((state_q == i2c_slave_pkg::ST_READ) && i_master_ack) ||
	                   ((state_q == i2c_slave_pkg::ST_DEV_ADDR) && addr_match && rw_bit);

	assign o_write = i_scl_fall && i_ack_bit && (state_q == i2c_slave_pkg::ST_WRITE);
	assign o_load  = i_scl_fall && i_lsb_bit;

	// ----------------------------------------------------------
	// State machine
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= i2c_slave_pkg::ST_IDLE;
		end else if (i_start) begin
			state_q <= i2c_slave_pkg::ST_DEV_ADDR;
		end else if (i_scl_fall && i_ack_bit) begin
			case (state_q)
				i2c_slave_pkg::ST_DEV_ADDR: begin
					if (!addr_match)
						state_q <= i2c_slave_pkg::ST_IDLE;
					else if (rw_bit)
						state_q <= i2c_slave_pkg::ST_READ;
					else
						state_q <= i2c_slave_pkg::ST_IDX_PTR;
				end
				// Master NACK ends the read burst
				i2c_slave_pkg::ST_READ: begin
					if (!i_master_ack)
						state_q <= i2c_slave_pkg::ST_IDLE;
				end
				i2c_slave_pkg::ST_IDX_PTR: state_q <= i2c_slave_pkg::ST_WRITE;
				default: state_q <= state_q;
			endcase
		end else if (i_stop) begin
			state_q <= i2c_slave_pkg::ST_IDLE;
		end
	end

	// Index loads after the pointer byte, else steps each ACK
	always_ff @(posedge clk) begin
		if (rst)
			o_index <= '0;
		else if (i_scl_fall && i_ack_bit) begin
			if (state_q == i2c_slave_pkg::ST_IDX_PTR)
				o_index <= i_rx_byte;
			else
				o_index <= o_index + 8'd1;
		end
	end

	// Transmit byte, MSB goes out first
	always_ff @(posedge clk) begin
		if (o_load)
			tx_q <= i_read_byte;
		else if (i_scl_fall)
			tx_q <= {tx_q[6:0], 1'b0};
	end

	// ----------------------------------------------------------
	// SDA release, 0 pulls the line low
	// ----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst)
			o_sda_release <= 1'b1;
		else if (i_stop || state_q == i2c_slave_pkg::ST_IDLE)
			o_sda_release <= 1'b1;
		else if (i_scl_fall && i_start)
			o_sda_release <= 1'b1;
		else if (i_scl_fall && i_lsb_bit)
			o_sda_release <= !slave_ack;
		else if (i_scl_fall && i_ack_bit)
			o_sda_release <= send_next ? tx_q[7] : 1'b1;
		else if (i_scl_fall && state_q == i2c_slave_pkg::ST_READ)
			o_sda_release <= tx_q[7];
		else if (i_scl_fall)
			o_sda_release <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tests/i2c_slave_properties.sv ====
// Concurrent assertions on controller reset, idle and write pulse behavior
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_properties (
	input wire logic                        clk,
	input wire logic                        rst,
	input wire i2c_slave_pkg::slave_state_e i_state,
	input wire logic                        i_sda_release,
	input wire logic                        i_write
);

	// ----------------------------------------------------------
	// Release behavior
	// ----------------------------------------------------------
	// First cycle out of reset leaves SDA alone
	release_after_reset: assert property (
		@(posedge clk) $past(rst) |-> i_sda_release
	) else $error("SDA release low right after reset");

	// Idle slave never pulls SDA
	release_when_idle: assert property (
		@(posedge clk) disable iff (rst)
		(i_state == i2c_slave_pkg::ST_IDLE) |-> i_sda_release
	) else $error("SDA pulled low while idle");

	// ----------------------------------------------------------
	// Write pulse
	// ----------------------------------------------------------
	write_only_in_write_state: assert property (
		@(posedge clk) disable iff (rst)
		i_write |-> (i_state == i2c_slave_pkg::ST_WRITE)
	) else $error("Write pulse outside write state");

endmodule

bind i2c_transfer_ctrl i2c_slave_properties u_properties (
	.clk(clk),
	.rst(rst),
	.i_state(state_q),
	.i_sda_release(o_sda_release),
	.i_write(o_write)
);

`default_nettype wire

// ==== tests/tb_i2c_slave.sv ====
// I2C slave testbench with bus master tasks, register map checks and summary
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_slave;

	localparam int CLK_PERIOD = 40;
	localparam int QUARTER    = 10;
	// Rough upper bound of frames in all tests
	localparam int NUM_FRAMES = 100;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * 9 * 4 * QUARTER + 2000;
	localparam i2c_slave_pkg::dev_addr_t DEV_ADDR = 7'h1A;

	logic clk = 1'b0;
	logic rst;
	logic m_scl;
	logic m_sda;
	logic sda_bus;
	i2c_slave_pkg::word_t data_out;
	logic end_op;
	logic sda_release;
	i2c_slave_pkg::word_t data_in;
	i2c_slave_pkg::word_t add;
	i2c_slave_pkg::word_t control;

	int errors = 0;
	int checks = 0;
	logic [31:0] lfsr = 32'h4d2d_6aae;
	// Expected writable bytes
	i2c_slave_pkg::byte_t exp_regs [24];
	i2c_slave_pkg::byte_t wr_buf [32];
	i2c_slave_pkg::byte_t rd_buf [32];

	// Open drain bus as wired AND of master and slave
	assign sda_bus = m_sda & sda_release;

	always #(CLK_PERIOD / 2) clk = ~clk;

	i2c_slave_top #(
		.DEVICE_ADDRESS(DEV_ADDR)
	) dut0 (
		.clk(clk), .rst(rst), .i_scl(m_scl), .i_sda(sda_bus),
		.i_data_out(data_out), .i_end_op(end_op),
		.o_sda_release(sda_release),
		.o_data_in(data_in), .o_add(add), .o_control(control)
	);

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------
	// Fibonacci LFSR with taps 32 22 2 1
	// One step per random bit
	function automatic i2c_slave_pkg::byte_t next_random_byte();
		logic fb;
		i2c_slave_pkg::byte_t b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			b = {b[6:0], fb};
		end
		return b;
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s expected 0x%0h actual 0x%0h", name, exp, got);
		end
	endtask

	// Base byte is the most significant one
	function automatic i2c_slave_pkg::word_t expected_word(input int base);
		i2c_slave_pkg::word_t w;
		for (int i = 0; i < 8; i++)
			w[8*(7-i) +: 8] = exp_regs[base + i];
		return w;
	endfunction

	task automatic wait_quarter();
		repeat (QUARTER) @(posedge clk);
	endtask

	// ----------------------------------------------------------
	// Bus master
	// ----------------------------------------------------------
	// Start from idle or as repeated start
	// Leading quarter lets the slave drop its ACK before SCL rises
	// Leaves SCL low
	task automatic bus_start();
		wait_quarter();
		m_sda <= 1'b1;
		wait_quarter();
		m_scl <= 1'b1;
		wait_quarter();
		m_sda <= 1'b0;
		wait_quarter();
		m_scl <= 1'b0;
	endtask

	task automatic bus_stop();
		wait_quarter();
		m_sda <= 1'b0;
		wait_quarter();
		m_scl <= 1'b1;
		wait_quarter();
		m_sda <= 1'b1;
		wait_quarter();
		wait_quarter();
	endtask

	// One bit with an optional one clock low glitch on SCL while high
	task automatic transfer_bit(input logic b, input logic glitch, output logic s);
		wait_quarter();
		m_sda <= b;
		wait_quarter();
		m_scl <= 1'b1;
		if (glitch) begin
			repeat (QUARTER / 2) @(posedge clk);
			m_scl <= 1'b0;
			@(posedge clk);
			m_scl <= 1'b1;
			repeat (QUARTER / 2 - 1) @(posedge clk);
		end else begin
			wait_quarter();
		end
		s = sda_bus;
		wait_quarter();
		m_scl <= 1'b0;
	endtask

	task automatic write_byte(input i2c_slave_pkg::byte_t d, input logic glitch,
			output logic ack);
		logic s;
		for (int i = 7; i >= 0; i--)
			transfer_bit(d[i], glitch, s);
		transfer_bit(1'b1, 1'b0, s);
		ack = ~s;
	endtask

	task automatic read_byte(input logic ack, output i2c_slave_pkg::byte_t d);
		logic s;
		for (int i = 0; i < 8; i++) begin
			transfer_bit(1'b1, 1'b0, s);
			d = {d[6:0], s};
		end
		transfer_bit(~ack, 1'b0, s);
	endtask

	// Index byte then n bytes from wr_buf
	task automatic write_regs(input i2c_slave_pkg::reg_index_t idx, input int n,
			input logic glitch);
		logic ack;
		bus_start();
		write_byte({DEV_ADDR, 1'b0}, 1'b0, ack);
		check_value($sformatf("addr ack idx 0x%02h", idx), 1, 64'(ack));
		write_byte(idx, 1'b0, ack);
		check_value($sformatf("index ack 0x%02h", idx), 1, 64'(ack));
		for (int i = 0; i < n; i++) begin
			write_byte(wr_buf[i], glitch, ack);
			check_value($sformatf("data ack 0x%02h", idx + i), 1, 64'(ack));
		end
		bus_stop();
	endtask

	// Index write and repeated start before n bytes into rd_buf
	task automatic read_regs(input i2c_slave_pkg::reg_index_t idx, input int n);
		logic ack;
		bus_start();
		write_byte({DEV_ADDR, 1'b0}, 1'b0, ack);
		check_value("read addr ack", 1, 64'(ack));
		write_byte(idx, 1'b0, ack);
		check_value("read index ack", 1, 64'(ack));
		bus_start();
		write_byte({DEV_ADDR, 1'b1}, 1'b0, ack);
		check_value("read dir ack", 1, 64'(ack));
		for (int i = 0; i < n; i++)
			read_byte(i != n - 1, rd_buf[i]);
		bus_stop();
	endtask

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	initial begin
		logic ack;
		i2c_slave_pkg::word_t result;
		rst      <= 1'b1;
		m_scl    <= 1'b1;
		m_sda    <= 1'b1;
		data_out <= '0;
		end_op   <= 1'b0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		repeat (20) @(posedge clk);

		// Burst write of all writable bytes
		for (int i = 0; i < 24; i++) begin
			wr_buf[i] = next_random_byte();
			exp_regs[i] = wr_buf[i];
		end
		write_regs(8'h00, 24, 1'b0);
		check_value("burst data_in", expected_word(0), data_in);
		check_value("burst add", expected_word(8), add);
		check_value("burst control", expected_word(16), control);

		// Burst read back
		read_regs(8'h00, 24);
		for (int i = 0; i < 24; i++)
			check_value($sformatf("burst read 0x%02h", i), 64'(exp_regs[i]),
				64'(rd_buf[i]));

		// Foreign address is not acknowledged
		bus_start();
		write_byte({7'h2B, 1'b0}, 1'b0, ack);
		check_value("wrong address ack", 0, 64'(ack));
		bus_stop();
		check_value("wrong address data_in", expected_word(0), data_in);
		check_value("wrong address add", expected_word(8), add);
		check_value("wrong address control", expected_word(16), control);

		// Result word and end flag
		for (int i = 0; i < 8; i++)
			result[8*i +: 8] = next_random_byte();
		data_out <= result;
		end_op   <= 1'b1;
		read_regs(8'h18, 8);
		for (int i = 0; i < 8; i++)
			check_value($sformatf("result byte %0d", i), 64'(result[8*(7-i) +: 8]),
				64'(rd_buf[i]));
		read_regs(8'h27, 1);
		check_value("end op flag", 1, 64'(rd_buf[0]));
		read_regs(8'h30, 1);
		check_value("unmapped read", 0, 64'(rd_buf[0]));

		// Filter configuration
		wr_buf[0] = 8'd2;
		wr_buf[1] = 8'd7;
		wr_buf[2] = 8'd9;
		write_regs(8'hFD, 3, 1'b0);
		read_regs(8'hFD, 3);
		check_value("filter zero raw", 2, 64'(rd_buf[0]));
		check_value("filter one raw", 7, 64'(rd_buf[1]));
		check_value("filter width raw", 9, 64'(rd_buf[2]));
		wr_buf[0] = 8'd1;
		wr_buf[1] = 8'd5;
		wr_buf[2] = 8'd6;
		write_regs(8'hFD, 3, 1'b0);

		// SCL glitches during data bits
		wr_buf[0] = next_random_byte();
		exp_regs[5] = wr_buf[0];
		write_regs(8'h05, 1, 1'b1);
		check_value("glitch data_in", expected_word(0), data_in);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout, the tests did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
